// ==== verilog/offload_pkg.sv ====
`default_nettype none

package offload_pkg;

    localparam int NUM_CHANNELS = 3;
    localparam int BUF_WORDS    = 32;
    localparam int WORD_W       = 32;
    localparam int WORD_BYTES   = WORD_W / 8;
    localparam int HOST_ADDR_W  = 64;
    localparam int RAM_ADDR_W   = 5;
    localparam int CSR_ADDR_W   = 12;

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [HOST_ADDR_W-1:0] host_addr_t;
    typedef logic [RAM_ADDR_W-1:0]  ram_addr_t;
    typedef logic [CSR_ADDR_W-1:0]  csr_addr_t;

    // Register map of the control slave.
    localparam csr_addr_t REG_CTRL    = 12'h000;
    localparam csr_addr_t REG_TIMEOUT = 12'h010;
    localparam csr_addr_t REG_BASE0   = 12'h018;
    localparam int        BASE_STRIDE = 8;

    typedef struct packed {
        logic      awvalid;
        csr_addr_t awaddr;
        logic      wvalid;
        word_t     wdata;
        logic      bready;
        logic      arvalid;
        csr_addr_t araddr;
        logic      rready;
    } csr_req_t;

    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        logic  arready;
        logic  rvalid;
        word_t rdata;
    } csr_rsp_t;

    typedef struct packed {
        logic       arvalid;
        host_addr_t araddr;
        logic       rready;
    } mem_rd_out_t;

    typedef struct packed {
        logic  arready;
        logic  rvalid;
        word_t rdata;
    } mem_rd_in_t;

    typedef struct packed {
        logic       awvalid;
        host_addr_t awaddr;
        logic       wvalid;
        word_t      wdata;
        logic       bready;
    } mem_wr_out_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } mem_wr_in_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_COPY,
        PH_SEND
    } run_phase_t;

endpackage

`default_nettype wire

// ==== verilog/host_ctrl_regs.sv ====
`default_nettype none

module host_ctrl_regs (
    input  wire                                                  ACLK,
    input  wire                                                  ARESET,
    input  wire offload_pkg::csr_req_t                           csr_req,
    output offload_pkg::csr_rsp_t                                csr_rsp,
    input  wire                                                  run_done,
    output logic                                                 start,
    output offload_pkg::word_t                                   timeout_cycles,
    output offload_pkg::host_addr_t [offload_pkg::NUM_CHANNELS-1:0] base_addr
);

    typedef enum logic [1:0] {
        WS_ADDR,
        WS_DATA,
        WS_RESP
    } wr_state_t;

    typedef enum logic {
        RS_ADDR,
        RS_DATA
    } rd_state_t;

    wr_state_t              wstate;
    rd_state_t              rstate;
    offload_pkg::csr_addr_t waddr;
    offload_pkg::csr_addr_t raddr;
    offload_pkg::word_t     rdata_q;
    offload_pkg::word_t     rd_word;
    logic                   done_q;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;
    logic                   r_hs;

    // Low word of a channel base at half 0, high word at half 1.
    function automatic offload_pkg::csr_addr_t base_reg(input int k, input int half);
        return offload_pkg::csr_addr_t'(offload_pkg::REG_BASE0 + offload_pkg::BASE_STRIDE * k
                                        + offload_pkg::WORD_BYTES * half);
    endfunction

    assign aw_hs = csr_req.awvalid && csr_rsp.awready;
    assign w_hs  = csr_req.wvalid && csr_rsp.wready;
    assign ar_hs = csr_req.arvalid && csr_rsp.arready;
    assign r_hs  = csr_req.rready && csr_rsp.rvalid;

    assign csr_rsp.awready = wstate == WS_ADDR;
    assign csr_rsp.wready  = wstate == WS_DATA;
    assign csr_rsp.bvalid  = wstate == WS_RESP;
    assign csr_rsp.arready = rstate == RS_ADDR;
    assign csr_rsp.rvalid  = rstate == RS_DATA;
    assign csr_rsp.rdata   = rdata_q;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wstate <= WS_ADDR;
            rstate <= RS_ADDR;
        end else begin
            case (wstate)
                WS_ADDR: if (aw_hs) wstate <= WS_DATA;
                WS_DATA: if (w_hs) wstate <= WS_RESP;
                WS_RESP: if (csr_req.bready) wstate <= WS_ADDR;
                default: wstate <= WS_ADDR;
            endcase
            case (rstate)
                RS_ADDR: if (ar_hs) rstate <= RS_DATA;
                RS_DATA: if (csr_req.rready) rstate <= RS_ADDR;
                default: rstate <= RS_ADDR;
            endcase
        end
    end

    // Read decode over the same map; unmapped addresses return zero.
    always_comb begin
        rd_word = '0;
        if (csr_req.araddr == offload_pkg::REG_CTRL) begin
            rd_word = offload_pkg::word_t'({done_q, start});
        end
        if (csr_req.araddr == offload_pkg::REG_TIMEOUT) begin
            rd_word = timeout_cycles;
        end
        for (int k = 0; k < offload_pkg::NUM_CHANNELS; k++) begin
            if (csr_req.araddr == base_reg(k, 0)) begin
                rd_word = base_addr[k][offload_pkg::WORD_W-1:0];
            end
            if (csr_req.araddr == base_reg(k, 1)) begin
                rd_word = base_addr[k][offload_pkg::HOST_ADDR_W-1:offload_pkg::WORD_W];
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            waddr <= csr_req.awaddr;
        end
        if (ar_hs) begin
            raddr   <= csr_req.araddr;
            rdata_q <= rd_word;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            start          <= 1'b0;
            timeout_cycles <= '0;
            base_addr      <= '0;
        end else begin
            if (run_done) begin
                start <= 1'b0;
            end else if (w_hs && waddr == offload_pkg::REG_CTRL) begin
                start <= csr_req.wdata[0];
            end
            if (w_hs && waddr == offload_pkg::REG_TIMEOUT) begin
                timeout_cycles <= csr_req.wdata;
            end
            for (int k = 0; k < offload_pkg::NUM_CHANNELS; k++) begin
                if (w_hs && waddr == base_reg(k, 0)) begin
                    base_addr[k][offload_pkg::WORD_W-1:0] <= csr_req.wdata;
                end
                if (w_hs && waddr == base_reg(k, 1)) begin
                    base_addr[k][offload_pkg::HOST_ADDR_W-1:offload_pkg::WORD_W] <= csr_req.wdata;
                end
            end
        end
    end

    // Done clears only when the completed read actually returned it set.
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            done_q <= 1'b0;
        end else if (run_done) begin
            done_q <= 1'b1;
        end else if (r_hs && raddr == offload_pkg::REG_CTRL && rdata_q[1]) begin
            done_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_channel.sv ====
`default_nettype none

module mem_channel (
    input  wire                              ACLK,
    input  wire                              ARESET,
    input  wire offload_pkg::run_phase_t     phase,
    input  wire offload_pkg::host_addr_t     base_addr,
    output offload_pkg::mem_rd_out_t         rd_out,
    input  wire offload_pkg::mem_rd_in_t     rd_in,
    output offload_pkg::mem_wr_out_t         wr_out,
    input  wire offload_pkg::mem_wr_in_t     wr_in,
    output logic                             copy_done,
    output logic                             send_done
);

    typedef enum logic [2:0] {
        MD_IDLE,
        MD_COPYING,
        MD_COPIED,
        MD_SENDING,
        MD_SENT
    } mode_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    offload_pkg::word_t      ram [offload_pkg::BUF_WORDS];
    mode_t                   mode;
    rd_state_t               rd_state;
    wr_state_t               wr_state;
    offload_pkg::ram_addr_t  offset;
    offload_pkg::host_addr_t bus_addr;
    logic                    active;
    logic                    r_hs;
    logic                    b_hs;
    logic                    last_word;

    // Phase back at idle abandons whatever step is in flight.
    assign active    = phase != offload_pkg::PH_IDLE;
    assign r_hs      = rd_in.rvalid && rd_out.rready;
    assign b_hs      = wr_in.bvalid && wr_out.bready;
    assign last_word = offset == offload_pkg::ram_addr_t'(offload_pkg::BUF_WORDS - 1);
    assign bus_addr  = base_addr + offload_pkg::host_addr_t'(offset) * offload_pkg::WORD_BYTES;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            mode <= MD_IDLE;
        end else if (!active) begin
            mode <= MD_IDLE;
        end else begin
            case (mode)
                MD_IDLE:    if (phase == offload_pkg::PH_COPY) mode <= MD_COPYING;
                MD_COPYING: if (r_hs && last_word) mode <= MD_COPIED;
                MD_COPIED:  if (phase == offload_pkg::PH_SEND) mode <= MD_SENDING;
                MD_SENDING: if (b_hs && last_word) mode <= MD_SENT;
                default:    mode <= mode;
            endcase
        end
    end

    // One offset serves both directions. It wraps to zero after the last word.
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            offset <= '0;
        end else if (mode == MD_IDLE) begin
            offset <= '0;
        end else if (r_hs || b_hs) begin
            offset <= offset + 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            rd_state <= RD_IDLE;
        end else if (!active) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: if (mode == MD_COPYING) rd_state <= RD_ADDR;
                RD_ADDR: if (rd_in.arready) rd_state <= RD_DATA;
                RD_DATA: if (rd_in.rvalid) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_state <= WR_IDLE;
        end else if (!active) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: if (mode == MD_SENDING) wr_state <= WR_ADDR;
                WR_ADDR: if (wr_in.awready) wr_state <= WR_DATA;
                WR_DATA: if (wr_in.wready) wr_state <= WR_RESP;
                WR_RESP: if (wr_in.bvalid) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (r_hs) begin
            ram[offset] <= rd_in.rdata;
        end
    end

    assign rd_out.arvalid = active && rd_state == RD_ADDR;
    assign rd_out.araddr  = bus_addr;
    assign rd_out.rready  = active && rd_state == RD_DATA;

    // Offset holds for the whole write, so the RAM word stays stable under WVALID.
    assign wr_out.awvalid = active && wr_state == WR_ADDR;
    assign wr_out.awaddr  = bus_addr;
    assign wr_out.wvalid  = active && wr_state == WR_DATA;
    assign wr_out.wdata   = ram[offset];
    assign wr_out.bready  = active && wr_state == WR_RESP;

    assign copy_done = active && mode inside {MD_COPIED, MD_SENDING, MD_SENT};
    assign send_done = active && mode == MD_SENT;

endmodule

`default_nettype wire

// ==== verilog/run_sequencer.sv ====
`default_nettype none

module run_sequencer (
    input  wire                                ACLK,
    input  wire                                ARESET,
    input  wire                                start,
    input  wire offload_pkg::word_t            timeout_cycles,
    input  wire [offload_pkg::NUM_CHANNELS-1:0] copy_done,
    input  wire [offload_pkg::NUM_CHANNELS-1:0] send_done,
    output offload_pkg::run_phase_t            phase,
    output logic                               run_done
);

    offload_pkg::word_t cycle_count;
    logic               all_copied;
    logic               all_sent;
    logic               expired;

    assign all_copied = &copy_done;
    assign all_sent   = &send_done;

    // A zero timeout never expires.
    assign expired = start && timeout_cycles != '0 && cycle_count > timeout_cycles;

    // Combinational so that start drops on the same edge the phase returns to idle.
    assign run_done = (phase == offload_pkg::PH_SEND && all_sent)
                   || (phase != offload_pkg::PH_IDLE && expired);

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            phase <= offload_pkg::PH_IDLE;
        end else if (run_done) begin
            phase <= offload_pkg::PH_IDLE;
        end else begin
            case (phase)
                offload_pkg::PH_IDLE: if (start) phase <= offload_pkg::PH_COPY;
                offload_pkg::PH_COPY: if (all_copied) phase <= offload_pkg::PH_SEND;
                default:              phase <= phase;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || !start) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/offload_top.sv ====
`default_nettype none

module offload_top (
    input  wire                              ACLK,
    input  wire                              ARESET,
    input  wire offload_pkg::csr_req_t       csr_req,
    output offload_pkg::csr_rsp_t            csr_rsp,
    output offload_pkg::mem_rd_out_t         mem_rd_out [offload_pkg::NUM_CHANNELS],
    input  wire offload_pkg::mem_rd_in_t     mem_rd_in  [offload_pkg::NUM_CHANNELS],
    output offload_pkg::mem_wr_out_t         mem_wr_out [offload_pkg::NUM_CHANNELS],
    input  wire offload_pkg::mem_wr_in_t     mem_wr_in  [offload_pkg::NUM_CHANNELS]
);

    logic                                                 start;
    logic                                                 run_done;
    offload_pkg::word_t                                   timeout_cycles;
    offload_pkg::host_addr_t [offload_pkg::NUM_CHANNELS-1:0] base_addr;
    offload_pkg::run_phase_t                              phase;
    logic [offload_pkg::NUM_CHANNELS-1:0]                 copy_done;
    logic [offload_pkg::NUM_CHANNELS-1:0]                 send_done;

    host_ctrl_regs u_regs (
        .ACLK           (ACLK),
        .ARESET         (ARESET),
        .csr_req        (csr_req),
        .csr_rsp        (csr_rsp),
        .run_done       (run_done),
        .start          (start),
        .timeout_cycles (timeout_cycles),
        .base_addr      (base_addr)
    );

    run_sequencer u_sequencer (
        .ACLK           (ACLK),
        .ARESET         (ARESET),
        .start          (start),
        .timeout_cycles (timeout_cycles),
        .copy_done      (copy_done),
        .send_done      (send_done),
        .phase          (phase),
        .run_done       (run_done)
    );

    // One buffer channel per host memory port.
    for (genvar k = 0; k < offload_pkg::NUM_CHANNELS; k++) begin : g_channel
        mem_channel u_channel (
            .ACLK      (ACLK),
            .ARESET    (ARESET),
            .phase     (phase),
            .base_addr (base_addr[k]),
            .rd_out    (mem_rd_out[k]),
            .rd_in     (mem_rd_in[k]),
            .wr_out    (mem_wr_out[k]),
            .wr_in     (mem_wr_in[k]),
            .copy_done (copy_done[k]),
            .send_done (send_done[k])
        );
    end

endmodule

`default_nettype wire

// ==== tests/host_mem_model.sv ====
`default_nettype none

module host_mem_model (
    input  wire                           ACLK,
    input  wire                           ARESET,
    input  wire [31:0]                    seed,
    input  wire [7:0]                     stall_lvl,
    input  wire                           hold_rvalid,
    input  wire                           log_clear,
    input  wire offload_pkg::mem_rd_out_t rd_out,
    output offload_pkg::mem_rd_in_t       rd_in,
    input  wire offload_pkg::mem_wr_out_t wr_out,
    output offload_pkg::mem_wr_in_t       wr_in,
    output offload_pkg::host_addr_t       read_addr,
    input  wire offload_pkg::word_t       read_word
);

    logic [31:0]             lcg = 32'd0;
    logic                    arready_q = 1'b0;
    logic                    rvalid_q = 1'b0;
    logic                    rd_busy = 1'b0;
    logic                    awready_q = 1'b0;
    logic                    wready_q = 1'b0;
    logic                    bvalid_q = 1'b0;
    logic [1:0]              wr_step = 2'd0;
    offload_pkg::host_addr_t rd_addr_q = '0;
    offload_pkg::host_addr_t wr_addr_q = '0;
    offload_pkg::word_t      wr_data_log [offload_pkg::host_addr_t];
    int                      wr_count_log [offload_pkg::host_addr_t];
    int                      wr_total = 0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int times_written(input offload_pkg::host_addr_t a);
        return wr_count_log.exists(a) ? wr_count_log[a] : 0;
    endfunction

    function automatic offload_pkg::word_t data_written(input offload_pkg::host_addr_t a);
        return wr_data_log.exists(a) ? wr_data_log[a] : '0;
    endfunction

    assign rd_in     = '{arready: arready_q, rvalid: rvalid_q, rdata: read_word};
    assign wr_in     = '{awready: awready_q, wready: wready_q, bvalid: bvalid_q};
    assign read_addr = rd_addr_q;

    // Each ready or valid is raised on a cycle where the random byte clears the stall level.
    always @(posedge ACLK) begin
        if (ARESET) begin
            lcg       <= seed;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            rd_busy   <= 1'b0;
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            wr_step   <= 2'd0;
        end else begin
            lcg <= lcg_next(lcg);
            if (!rd_busy) begin
                if (rd_out.arvalid && arready_q) begin
                    rd_addr_q <= rd_out.araddr;
                    rd_busy   <= 1'b1;
                    arready_q <= 1'b0;
                end else begin
                    arready_q <= lcg[15:8] >= stall_lvl;
                end
            end else if (rvalid_q) begin
                if (rd_out.rready) begin
                    rvalid_q <= 1'b0;
                    rd_busy  <= 1'b0;
                end
            end else begin
                rvalid_q <= !hold_rvalid && lcg[23:16] >= stall_lvl;
            end
            case (wr_step)
                2'd0: begin
                    if (wr_out.awvalid && awready_q) begin
                        wr_addr_q <= wr_out.awaddr;
                        awready_q <= 1'b0;
                        wr_step   <= 2'd1;
                    end else begin
                        awready_q <= lcg[31:24] >= stall_lvl;
                    end
                end
                2'd1: begin
                    if (wr_out.wvalid && wready_q) begin
                        wr_data_log[wr_addr_q] = wr_out.wdata;
                        wr_count_log[wr_addr_q] = times_written(wr_addr_q) + 1;
                        wr_total = wr_total + 1;
                        wready_q <= 1'b0;
                        wr_step  <= 2'd2;
                    end else begin
                        wready_q <= lcg[31:24] >= stall_lvl;
                    end
                end
                default: begin
                    if (bvalid_q) begin
                        if (wr_out.bready) begin
                            bvalid_q <= 1'b0;
                            wr_step  <= 2'd0;
                        end
                    end else begin
                        bvalid_q <= lcg[31:24] >= stall_lvl;
                    end
                end
            endcase
        end
        if (log_clear) begin
            wr_data_log.delete();
            wr_count_log.delete();
            wr_total = 0;
        end
    end

endmodule

`default_nettype wire

// ==== tests/offload_properties.sv ====
`default_nettype none

module offload_properties (
    input wire                           ACLK,
    input wire                           ARESET,
    input wire offload_pkg::run_phase_t  phase,
    input wire offload_pkg::mem_rd_out_t rd_out,
    input wire offload_pkg::mem_rd_in_t  rd_in,
    input wire offload_pkg::mem_wr_out_t wr_out,
    input wire offload_pkg::mem_wr_in_t  wr_in
);

    int fail_count = 0;

    // A run that drops back to idle may abandon a pending request.
    ar_hold: assert property (@(posedge ACLK) disable iff (ARESET)
        rd_out.arvalid && !rd_in.arready |=> phase == offload_pkg::PH_IDLE
            || (rd_out.arvalid && $stable(rd_out.araddr)))
        else begin
            $error("ARVALID or ARADDR changed before the read address was accepted");
            fail_count++;
        end

    aw_hold: assert property (@(posedge ACLK) disable iff (ARESET)
        wr_out.awvalid && !wr_in.awready |=> phase == offload_pkg::PH_IDLE
            || (wr_out.awvalid && $stable(wr_out.awaddr)))
        else begin
            $error("AWVALID or AWADDR changed before the write address was accepted");
            fail_count++;
        end

    w_hold: assert property (@(posedge ACLK) disable iff (ARESET)
        wr_out.wvalid && !wr_in.wready |=> phase == offload_pkg::PH_IDLE
            || (wr_out.wvalid && $stable(wr_out.wdata)))
        else begin
            $error("WVALID or WDATA changed before the write data was accepted");
            fail_count++;
        end

    // Reads of every channel finish before any write starts.
    no_write_in_copy: assert property (@(posedge ACLK) disable iff (ARESET)
        phase == offload_pkg::PH_COPY |-> !wr_out.awvalid && !wr_out.wvalid)
        else begin
            $error("Write request seen while the run is still copying");
            fail_count++;
        end

endmodule

bind mem_channel offload_properties u_props (
    .ACLK   (ACLK),
    .ARESET (ARESET),
    .phase  (phase),
    .rd_out (rd_out),
    .rd_in  (rd_in),
    .wr_out (wr_out),
    .wr_in  (wr_in)
);

`default_nettype wire

// ==== tests/offload_tb.sv ====
`default_nettype none

module offload_tb;

    localparam int          NCH        = offload_pkg::NUM_CHANNELS;
    localparam int          HS_LIMIT   = 100;
    localparam int          POLL_LIMIT = 1000;
    localparam logic [31:0] LCG_SEED   = 32'd28871;

    logic                     ACLK = 1'b0;
    logic                     ARESET;
    offload_pkg::csr_req_t    csr_req;
    offload_pkg::csr_rsp_t    csr_rsp;
    offload_pkg::mem_rd_out_t mem_rd_out [NCH];
    offload_pkg::mem_rd_in_t  mem_rd_in  [NCH];
    offload_pkg::mem_wr_out_t mem_wr_out [NCH];
    offload_pkg::mem_wr_in_t  mem_wr_in  [NCH];
    offload_pkg::host_addr_t  read_addr  [NCH];
    offload_pkg::word_t       read_word  [NCH];
    offload_pkg::host_addr_t  bases      [NCH];
    int                       prop_fails [NCH];
    logic [7:0]               stall_lvl;
    logic [NCH-1:0]           hold_rvalid;
    logic                     log_clear;
    event                     verify_ev;
    int                       verified;
    int                       expect_writes;
    int                       checks;
    int                       errors;

    always #4 ACLK = ~ACLK;

    offload_top DUT (
        .ACLK       (ACLK),
        .ARESET     (ARESET),
        .csr_req    (csr_req),
        .csr_rsp    (csr_rsp),
        .mem_rd_out (mem_rd_out),
        .mem_rd_in  (mem_rd_in),
        .mem_wr_out (mem_wr_out),
        .mem_wr_in  (mem_wr_in)
    );

    // Expected memory content, mixed from every address bit.
    function automatic offload_pkg::word_t ref_word(input offload_pkg::host_addr_t addr);
        offload_pkg::word_t h;
        h = addr[31:0] ^ {addr[47:32], addr[63:48]};
        h = h * 32'h9E37_79B1;
        h = h ^ (h >> 13) ^ 32'hC3A5_5A3C;
        return h;
    endfunction

    function automatic offload_pkg::csr_addr_t base_reg_addr(input int k, input int half);
        return offload_pkg::csr_addr_t'(offload_pkg::REG_BASE0 + offload_pkg::BASE_STRIDE * k
                                        + 4 * half);
    endfunction

    for (genvar k = 0; k < NCH; k++) begin : g_mem
        host_mem_model u_mem (
            .ACLK        (ACLK),
            .ARESET      (ARESET),
            .seed        (LCG_SEED + 32'(k) * 32'd7919),
            .stall_lvl   (stall_lvl),
            .hold_rvalid (hold_rvalid[k]),
            .log_clear   (log_clear),
            .rd_out      (mem_rd_out[k]),
            .rd_in       (mem_rd_in[k]),
            .wr_out      (mem_wr_out[k]),
            .wr_in       (mem_wr_in[k]),
            .read_addr   (read_addr[k]),
            .read_word   (read_word[k])
        );

        assign read_word[k] = ref_word(read_addr[k]);

        // Failures of the memory port assertions bound into this channel.
        assign prop_fails[k] = DUT.g_channel[k].u_channel.u_props.fail_count;

        // Write-back of word i lands at base plus 4i, exactly once.
        always @(verify_ev) begin : verify
            offload_pkg::host_addr_t a;
            compare_value($sformatf("ch%0d write count", k), u_mem.wr_total, expect_writes);
            if (expect_writes != 0) begin
                for (int i = 0; i < offload_pkg::BUF_WORDS; i++) begin
                    a = bases[k] + offload_pkg::host_addr_t'(4 * i);
                    compare_value($sformatf("ch%0d writes at %h", k, a),
                                  u_mem.times_written(a), 1);
                    compare_value($sformatf("ch%0d wdata at %h", k, a),
                                  u_mem.data_written(a), ref_word(a));
                end
            end
            verified++;
        end
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR time %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Value mismatches plus assertion failures on any channel.
    function automatic int fault_count();
        int total;
        total = errors;
        for (int k = 0; k < NCH; k++) begin
            total += prop_fails[k];
        end
        return total;
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s.", what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic step_with_limit(inout int n, input int limit, input string what);
        @(posedge ACLK);
        n++;
        if (n > limit) abort_run(what);
    endtask

    task automatic write_reg(input offload_pkg::csr_addr_t addr, input offload_pkg::word_t data);
        int n;
        @(posedge ACLK);
        csr_req.awvalid <= 1'b1;
        csr_req.awaddr  <= addr;
        n = 0;
        do step_with_limit(n, HS_LIMIT, "AWREADY"); while (!csr_rsp.awready);
        csr_req.awvalid <= 1'b0;
        csr_req.wvalid  <= 1'b1;
        csr_req.wdata   <= data;
        n = 0;
        do step_with_limit(n, HS_LIMIT, "WREADY"); while (!csr_rsp.wready);
        csr_req.wvalid <= 1'b0;
        csr_req.bready <= 1'b1;
        n = 0;
        do step_with_limit(n, HS_LIMIT, "BVALID"); while (!csr_rsp.bvalid);
        csr_req.bready <= 1'b0;
    endtask

    task automatic read_reg(input offload_pkg::csr_addr_t addr, output offload_pkg::word_t data);
        int n;
        @(posedge ACLK);
        csr_req.arvalid <= 1'b1;
        csr_req.araddr  <= addr;
        n = 0;
        do step_with_limit(n, HS_LIMIT, "ARREADY"); while (!csr_rsp.arready);
        csr_req.arvalid <= 1'b0;
        csr_req.rready  <= 1'b1;
        n = 0;
        do step_with_limit(n, HS_LIMIT, "RVALID"); while (!csr_rsp.rvalid);
        data = csr_rsp.rdata;
        csr_req.rready <= 1'b0;
    endtask

    task automatic expect_reg(input offload_pkg::csr_addr_t addr, input offload_pkg::word_t exp,
                              input string name);
        offload_pkg::word_t got;
        read_reg(addr, got);
        compare_value(name, got, exp);
    endtask

    task automatic program_bases();
        for (int k = 0; k < NCH; k++) begin
            write_reg(base_reg_addr(k, 0), bases[k][31:0]);
            write_reg(base_reg_addr(k, 1), bases[k][63:32]);
        end
    endtask

    // Clears the memory logs, starts a run and polls until done reads set.
    task automatic run_to_done(input offload_pkg::word_t limit, output offload_pkg::word_t ctrl);
        int polls;
        @(posedge ACLK);
        log_clear <= 1'b1;
        @(posedge ACLK);
        log_clear <= 1'b0;
        write_reg(offload_pkg::REG_TIMEOUT, limit);
        write_reg(offload_pkg::REG_CTRL, 32'h1);
        polls = 0;
        do begin
            read_reg(offload_pkg::REG_CTRL, ctrl);
            polls++;
            if (polls > POLL_LIMIT) abort_run("the done bit");
        end while (!ctrl[1]);
    endtask

    task automatic verify_writeback(input int count);
        int n;
        expect_writes = count;
        verified      = 0;
        -> verify_ev;
        n = 0;
        while (verified < NCH) step_with_limit(n, HS_LIMIT, "the write-back check");
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("Test %0d %s: %s", num, name, fault_count() == errs_before ? "ok" : "FAILED");
    endtask

    initial begin
        offload_pkg::word_t ctrl;
        int                 errs0;
        ARESET      = 1'b1;
        csr_req     = '0;
        stall_lvl   = 8'd0;
        hold_rvalid = '0;
        log_clear   = 1'b0;
        checks      = 0;
        errors      = 0;
        repeat (5) @(posedge ACLK);
        ARESET <= 1'b0;

        errs0 = fault_count();
        expect_reg(offload_pkg::REG_CTRL, 32'h0, "CTRL after reset");
        expect_reg(offload_pkg::REG_TIMEOUT, 32'h0, "TIMEOUT after reset");
        for (int k = 0; k < NCH; k++) begin
            expect_reg(base_reg_addr(k, 0), 32'h0, $sformatf("BASE%0d_LO after reset", k));
            expect_reg(base_reg_addr(k, 1), 32'h0, $sformatf("BASE%0d_HI after reset", k));
            bases[k] = 64'h0000_00A5_0000_0000 + 64'h0000_0001_1000_0400 * (k + 1);
        end
        program_bases();
        write_reg(offload_pkg::REG_TIMEOUT, 32'h0BAD_F00D);
        expect_reg(offload_pkg::REG_TIMEOUT, 32'h0BAD_F00D, "TIMEOUT readback");
        for (int k = 0; k < NCH; k++) begin
            expect_reg(base_reg_addr(k, 0), bases[k][31:0], $sformatf("BASE%0d_LO", k));
            expect_reg(base_reg_addr(k, 1), bases[k][63:32], $sformatf("BASE%0d_HI", k));
        end
        expect_reg(12'h004, 32'h0, "unmapped 0x004");
        expect_reg(base_reg_addr(NCH, 0), 32'h0, "unmapped past last base");
        expect_reg(12'hFFC, 32'h0, "unmapped 0xFFC");
        report_test(1, "register readback", errs0);

        errs0 = fault_count();
        stall_lvl <= 8'd40;
        for (int k = 0; k < NCH; k++) begin
            bases[k] = 64'h0000_0010_0000_0000 * (k + 1) + 64'h0000_0000_0004_0000 * k;
        end
        program_bases();
        run_to_done(32'h0, ctrl);
        verify_writeback(offload_pkg::BUF_WORDS);
        report_test(2, "full run", errs0);

        errs0 = fault_count();
        compare_value("CTRL at done", ctrl, 32'h2);
        expect_reg(offload_pkg::REG_CTRL, 32'h0, "CTRL after done read");
        report_test(3, "done clear", errs0);

        errs0 = fault_count();
        stall_lvl <= 8'd200;
        for (int k = 0; k < NCH; k++) begin
            bases[k] = 64'hFFFF_0000_8000_0000 - 64'h0000_0000_0010_0000 * k;
        end
        program_bases();
        run_to_done(32'h0, ctrl);
        compare_value("CTRL at done", ctrl, 32'h2);
        verify_writeback(offload_pkg::BUF_WORDS);
        report_test(4, "back-pressure", errs0);

        // Channel 1 never sees read data, so only the timeout can end the run.
        errs0 = fault_count();
        stall_lvl      <= 8'd40;
        hold_rvalid[1] <= 1'b1;
        run_to_done(32'd200, ctrl);
        compare_value("CTRL at timeout", ctrl, 32'h2);
        verify_writeback(0);
        expect_reg(offload_pkg::REG_CTRL, 32'h0, "CTRL after timeout");
        report_test(5, "timeout", errs0);

        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, fault_count() - errors);
        if (fault_count() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/offload_pkg.sv
verilog/host_ctrl_regs.sv
verilog/mem_channel.sv
verilog/run_sequencer.sv
verilog/offload_top.sv
tests/host_mem_model.sv
tests/offload_properties.sv
tests/offload_tb.sv
